/* sim.f */
logic/parking_pkg.sv
logic/lot_ifs.sv
logic/order_queue.sv
logic/slot_table.sv
logic/slot_allocator.sv
logic/fee_meter.sv
logic/lift_controller.sv
logic/parking_lot_top.sv
sim/tb_parking_lot.sv

/* run.sh */
#!/bin/sh
# Build and run the car park testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_parking_lot -f sim.f -o tb_parking_lot

./obj_dir/tb_parking_lot > sim.log 2>&1 || true
cat sim.log

# Pass only when the testbench reported it
grep -q "SIMULATION PASSED" sim.log

/* sim/tb_parking_lot.sv */
// Car park testbench with clock, reset, order stimulus and a reference occupancy model
// Checks allocation, retrieval, fees, queueing, lift motion and free-place counts
`timescale 1ns/1ps
`default_nettype none

module tb_parking_lot
	import parking_pkg::*;
();

	typedef enum int {pulse_park, pulse_deliver, pulse_reject} pulse_t;

	logic clock;
	logic reset;
	logic park_request;
	logic retrieve_request;
	plate_t plate;
	logic queue_full;
	floor_t current_floor;
	logic busy;
	logic park_done;
	floor_t park_floor;
	place_t park_place;
	logic deliver;
	fee_t fee;
	logic reject;
	logic [3:0] empty_sedan;
	logic [3:0] empty_suv;

	// Reference occupancy and the cycle each car was stored
	plate_t model_lot [1:num_floors][0:1];
	int park_cycle [1:num_floors][0:1];

	// Orders sent but not yet finished, oldest first
	logic pend_exit [$];
	plate_t pend_plate [$];
	logic burst_exit [$];
	plate_t burst_plate [$];

	int cycle_count = 0;
	int order_count = 0;
	int pulse_count = 0;

	parking_lot_top UUT (
		.clock(clock),
		.reset(reset),
		.park_request(park_request),
		.retrieve_request(retrieve_request),
		.plate(plate),
		.queue_full(queue_full),
		.current_floor(current_floor),
		.busy(busy),
		.park_done(park_done),
		.park_floor(park_floor),
		.park_place(park_place),
		.deliver(deliver),
		.fee(fee),
		.reject(reject),
		.empty_sedan(empty_sedan),
		.empty_suv(empty_suv)
	);

	always #4 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
	end

	always @(negedge clock) begin
		if (!reset && (park_done || deliver || reject)) begin
			pulse_count <= pulse_count + 1;
		end
	end

	// Lift motion and ending pulses
	a_floor_step: assert property (@(posedge clock) disable iff (reset)
		({1'b0, current_floor} <= {1'b0, $past(current_floor)} + 4'd1) &&
		({1'b0, current_floor} + 4'd1 >= {1'b0, $past(current_floor)}))
		else report_failure("current_floor moved by more than one floor in a cycle");

	a_floor_range: assert property (@(posedge clock) disable iff (reset)
		!$isunknown(current_floor) && current_floor <= floor_t'(num_floors))
		else report_failure("current_floor left the range of floors 0 to 7");

	a_ground_when_idle: assert property (@(posedge clock) disable iff (reset)
		!busy |-> current_floor == '0)
		else report_failure("lift was away from floor 0 while busy was low");

	a_single_pulse: assert property (@(posedge clock) disable iff (reset)
		$onehot0({park_done, deliver, reject}))
		else report_failure("more than one ending pulse in the same cycle");

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input int got, input int expected);
		assert (got == expected)
		else report_failure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h",
			name, got, expected));
	endtask

	function automatic int empty_places(input int parity);
		int total;
		total = 0;
		for (int f = 1; f <= num_floors; f++) begin
			for (int p = 0; p < 2; p++) begin
				if (f % 2 == parity && model_lot[f][p] == '0) begin
					total++;
				end
			end
		end
		return total;
	endfunction

	// Lowest floor of the class parity, left before right
	function automatic logic choose_place(input plate_t car, output floor_t f_out,
		output place_t p_out);
		logic disabled;
		logic suv;
		logic allowed;
		disabled = (car[15:12] == class_disabled);
		suv = car[0];
		f_out = '0;
		p_out = 1'b0;
		for (int f = 1; f <= num_floors; f++) begin
			allowed = (f % 2 == 1) ? (suv || empty_places(0) == 0) : !suv;
			if (allowed && model_lot[f][0] == '0 && (disabled || f > reserved_top_floor)) begin
				f_out = floor_t'(f);
				p_out = 1'b0;
				return 1'b1;
			end
			if (allowed && model_lot[f][1] == '0) begin
				f_out = floor_t'(f);
				p_out = 1'b1;
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	function automatic logic find_car(input plate_t car, output floor_t f_out,
		output place_t p_out);
		f_out = '0;
		p_out = 1'b0;
		for (int f = 1; f <= num_floors; f++) begin
			for (int p = 1; p >= 0; p--) begin
				if (model_lot[f][p] == car) begin
					f_out = floor_t'(f);
					p_out = place_t'(p);
					return 1'b1;
				end
			end
		end
		return 1'b0;
	endfunction

	function automatic plate_t random_plate(input logic [3:0] tag, input logic suv);
		plate_t car;
		car = plate_t'($urandom);
		car[15:12] = 4'h1 + 4'($urandom % 7);
		car[11:8] = tag;
		car[0] = suv;
		return car;
	endfunction

	task automatic check_counts();
		check_value("empty_sedan", empty_sedan, empty_places(0));
		check_value("empty_suv", empty_suv, empty_places(1));
	endtask

	// Rate 2 reaches the 255 limit after about 128 parked cycles
	task automatic check_fee(input plate_t car, input int stay);
		if (car[15:12] == class_disabled) begin
			check_value("fee", fee, 0);
		end else if (car[15:12] == class_hybrid || (stay >= 120 && stay <= 200)) begin
			assert (fee != '0)
			else report_failure($sformatf("Mismatch fee: got 0x%0h, expected nonzero", fee));
		end else if (stay > 200) begin
			check_value("fee", fee, fee_max);
		end else begin
			assert (fee != '0 && fee[0] == 1'b0)
			else report_failure($sformatf("Mismatch fee: got 0x%0h, expected even and nonzero",
				fee));
		end
	endtask

	task automatic send_request(input logic exit_order, input plate_t car);
		assert (!queue_full)
		else report_failure("queue_full was high when a request was due");
		plate = car;
		park_request = !exit_order;
		retrieve_request = exit_order;
		pend_exit.push_back(exit_order);
		pend_plate.push_back(car);
		order_count++;
		@(negedge clock);
		park_request = 1'b0;
		retrieve_request = 1'b0;
	endtask

	task automatic wait_for_pulse(output pulse_t kind);
		logic seen;
		seen = 1'b0;
		kind = pulse_reject;
		for (int n = 0; n < 64 && !seen; n++) begin
			@(negedge clock);
			seen = park_done || deliver || reject;
			if (park_done) begin
				kind = pulse_park;
			end else if (deliver) begin
				kind = pulse_deliver;
			end
		end
		if (!seen) begin
			report_failure("no park_done, deliver or reject within 64 cycles");
		end
	endtask

	task automatic wait_busy_level(input logic level);
		for (int n = 0; n < 64 && busy != level; n++) begin
			@(negedge clock);
		end
		if (busy != level) begin
			report_failure("busy did not reach the expected level within 64 cycles");
		end
	endtask

	// Each ending pulse belongs to the oldest unfinished order
	task automatic finish_orders(input int count);
		pulse_t kind;
		pulse_t expected;
		logic exit_order;
		plate_t car;
		floor_t f;
		place_t p;
		logic ok;
		repeat (count) begin
			wait_for_pulse(kind);
			exit_order = pend_exit.pop_front();
			car = pend_plate.pop_front();
			if (exit_order) begin
				ok = find_car(car, f, p);
				expected = ok ? pulse_deliver : pulse_reject;
			end else begin
				ok = choose_place(car, f, p);
				expected = ok ? pulse_park : pulse_reject;
			end
			check_value("ending pulse", kind, expected);
			if (kind == pulse_park) begin
				check_value("park_floor", park_floor, f);
				check_value("park_place", park_place, p);
				model_lot[f][p] = car;
				park_cycle[f][p] = cycle_count;
				// Store lands on the next edge
				@(negedge clock);
				check_counts();
			end else if (kind == pulse_deliver) begin
				check_fee(car, cycle_count - park_cycle[f][p]);
				model_lot[f][p] = '0;
				check_counts();
			end else begin
				check_value("current_floor", current_floor, 0);
			end
		end
	endtask

	task automatic serve(input logic exit_order, input plate_t car);
		send_request(exit_order, car);
		finish_orders(1);
	endtask

	task automatic queue_burst(input logic exit_order, input plate_t car);
		burst_exit.push_back(exit_order);
		burst_plate.push_back(car);
	endtask

	task automatic send_burst();
		for (int i = 0; i < burst_plate.size(); i++) begin
			send_request(burst_exit[i], burst_plate[i]);
		end
		check_value("queue_full", queue_full, 1);
	endtask

	initial begin
		plate_t r0;
		plate_t r1;
		plate_t r2;
		plate_t r3;
		void'($urandom(32'h03e4_5eea));
		clock = 1'b0;
		reset = 1'b1;
		park_request = 1'b0;
		retrieve_request = 1'b0;
		plate = '0;
		for (int f = 1; f <= num_floors; f++) begin
			model_lot[f][0] = '0;
			model_lot[f][1] = '0;
		end
		repeat (8) @(negedge clock);
		reset = 1'b0;
		check_value("current_floor", current_floor, 0);
		check_value("busy", busy, 0);
		check_value("park_done", park_done, 0);
		check_value("deliver", deliver, 0);
		check_value("reject", reject, 0);
		check_value("fee", fee, 0);
		check_value("queue_full", queue_full, 0);
		check_value("empty_sedan", empty_sedan, 6);
		check_value("empty_suv", empty_suv, 8);

		// Disabled car, sedans, SUVs and a hybrid
		serve(1'b0, 16'h9002);
		serve(1'b0, 16'h1234);
		serve(1'b0, 16'h1235);
		serve(1'b0, 16'h8011);
		serve(1'b0, 16'h2346);
		// Unknown plate, then short stays
		serve(1'b1, 16'h7777);
		serve(1'b1, 16'h9002);
		serve(1'b1, 16'h8011);
		serve(1'b1, 16'h2346);
		// Fill the even floors up to the reserved left place
		serve(1'b0, 16'h3000);
		serve(1'b0, 16'h3002);
		serve(1'b0, 16'h3004);
		serve(1'b0, 16'h3006);
		serve(1'b0, 16'h3008);
		serve(1'b0, 16'h9004);
		// Even floors full, so this sedan overflows
		serve(1'b0, 16'h3008);

		// Long stay for the early sedan
		wait_busy_level(1'b0);
		repeat (210) @(negedge clock);
		serve(1'b1, 16'h1234);

		r0 = random_plate(4'h8, 1'b1);
		r1 = random_plate(4'h9, 1'b0);
		r2 = random_plate(4'ha, 1'b1);
		r3 = random_plate(4'hb, 1'b0);
		queue_burst(1'b0, r0);
		queue_burst(1'b0, r1);
		queue_burst(1'b0, r2);
		queue_burst(1'b1, r0);
		queue_burst(1'b1, 16'h5555);
		queue_burst(1'b0, r3);
		queue_burst(1'b1, 16'h3000);
		queue_burst(1'b1, r1);

		// Burst arrives while the lift is up on floor 6
		send_request(1'b1, 16'h3006);
		wait_busy_level(1'b1);
		fork
			send_burst();
			finish_orders(9);
		join
		wait_busy_level(1'b0);
		repeat (4) @(negedge clock);

		if (pulse_count == order_count) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			report_failure($sformatf("Mismatch pulse_count: got 0x%0h, expected 0x%0h",
				pulse_count, order_count));
		end
	end

endmodule

`default_nettype wire

/* logic/parking_lot_top.sv */
// Car park top level with queue, slot table, allocator, fee meter and lift
`timescale 1ns/1ps
`default_nettype none

module parking_lot_top
	import parking_pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire logic park_request,
	input wire logic retrieve_request,
	input plate_t plate,
	output logic queue_full,
	output floor_t current_floor,
	output logic busy,
	output logic park_done,
	output floor_t park_floor,
	output place_t park_place,
	output logic deliver,
	output fee_t fee,
	output logic reject,
	output logic [3:0] empty_sedan,
	output logic [3:0] empty_suv
);

	lot_map_t lot;
	logic found;
	floor_t alloc_floor;
	place_t alloc_place;

	order_if orders ();
	slot_if slots ();

	order_queue u_order_queue (
		.clock(clock),
		.reset(reset),
		.park_request(park_request),
		.retrieve_request(retrieve_request),
		.plate(plate),
		.queue_full(queue_full),
		.orders(orders.source)
	);

	slot_table u_slot_table (
		.clock(clock),
		.reset(reset),
		.slots(slots.storage),
		.lot(lot),
		.empty_sedan(empty_sedan),
		.empty_suv(empty_suv)
	);

	slot_allocator u_slot_allocator (
		.lot(lot),
		.orders(orders.monitor),
		.found(found),
		.floor(alloc_floor),
		.place(alloc_place)
	);

	fee_meter u_fee_meter (
		.clock(clock),
		.reset(reset),
		.slots(slots.monitor),
		.fee(fee)
	);

	lift_controller u_lift_controller (
		.clock(clock),
		.reset(reset),
		.orders(orders.sink),
		.slots(slots.lift),
		.found(found),
		.alloc_floor(alloc_floor),
		.alloc_place(alloc_place),
		.current_floor(current_floor),
		.busy(busy),
		.park_done(park_done),
		.park_floor(park_floor),
		.park_place(park_place),
		.deliver(deliver),
		.reject(reject)
	);

endmodule

`default_nettype wire

/* logic/lift_controller.sv */
// Lift FSM that serves one order at a time and stores or removes cars
`timescale 1ns/1ps
`default_nettype none

module lift_controller
	import parking_pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	order_if.sink orders,
	slot_if.lift slots,
	input wire logic found,
	input floor_t alloc_floor,
	input place_t alloc_place,
	output floor_t current_floor,
	output logic busy,
	output logic park_done,
	output floor_t park_floor,
	output place_t park_place,
	output logic deliver,
	output logic reject
);

	typedef enum logic [1:0] {idle, rise, descend, refuse} state_t;

	state_t state;
	logic is_exit;
	floor_t target_floor;
	place_t target_place;
	plate_t car_plate;
	logic order_ok;
	logic arrive;

	assign orders.pop = (state == idle) && orders.valid;
	assign slots.lookup_plate = orders.plate;

	// Retrieve needs a plate match, park needs a free place
	assign order_ok = orders.exit ? slots.hit : found;
	assign arrive = (state == rise) && (current_floor == target_floor);

	assign slots.wr_en = arrive;
	assign slots.wr_floor = target_floor;
	assign slots.wr_place = target_place;
	assign slots.wr_plate = is_exit ? '0 : car_plate;

	assign busy = (state != idle);
	assign park_done = arrive && !is_exit;
	assign park_floor = target_floor;
	assign park_place = target_place;
	assign deliver = (state == descend) && (current_floor == '0) && is_exit;
	assign reject = (state == refuse);

	always_ff @(posedge clock) begin
		if (orders.pop) begin
			car_plate <= orders.plate;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
			current_floor <= '0;
			is_exit <= 1'b0;
			target_floor <= '0;
			target_place <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (orders.valid) begin
						is_exit <= orders.exit;
						if (orders.exit) begin
							target_floor <= slots.hit_floor;
							target_place <= slots.hit_place;
						end else begin
							target_floor <= alloc_floor;
							target_place <= alloc_place;
						end
						state <= order_ok ? rise : refuse;
					end
				end
				rise: begin
					// Target is at least floor 1, so the first step down is safe
					if (current_floor == target_floor) begin
						current_floor <= current_floor - 3'd1;
						state <= descend;
					end else begin
						current_floor <= current_floor + 3'd1;
					end
				end
				descend: begin
					if (current_floor == '0) begin
						state <= idle;
					end else begin
						current_floor <= current_floor - 3'd1;
					end
				end
				refuse: state <= idle;
				default: state <= idle;
			endcase
		end
	end

	// Lift never passes its target and moves at most one floor per cycle
	a_floor_limit: assert property (
		@(posedge clock) disable iff (reset)
		current_floor <= target_floor
	) else $error("lift_controller: current_floor above the target floor");

	a_floor_step: assert property (
		@(posedge clock) disable iff (reset)
		!$stable(current_floor) |->
			({1'b0, current_floor} == {1'b0, $past(current_floor)} + 4'd1) ||
			({1'b0, current_floor} + 4'd1 == {1'b0, $past(current_floor)})
	) else $error("lift_controller: current_floor jumped");

endmodule

`default_nettype wire

/* logic/fee_meter.sv */
// Per-place saturating fee counters and fee of the last removed car
`timescale 1ns/1ps
`default_nettype none

module fee_meter
	import parking_pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	slot_if.monitor slots,
	output fee_t fee
);

	fee_t counts [1:num_floors][0:1];
	fee_t rates [1:num_floors][0:1];
	logic [num_floors:1][1:0] occupied;
	logic store;
	logic remove;

	function automatic fee_t rate_of(input plate_t car);
		if (car[15:12] == class_disabled) begin
			return rate_disabled;
		end else if (car[15:12] == class_hybrid) begin
			return rate_hybrid;
		end
		return rate_standard;
	endfunction

	function automatic fee_t sat_add(input fee_t acc, input fee_t rate);
		logic [8:0] sum;
		sum = {1'b0, acc} + {1'b0, rate};
		if (sum > {1'b0, fee_max}) begin
			return fee_max;
		end
		return sum[7:0];
	endfunction

	assign store = slots.wr_en && (slots.wr_plate != '0);
	assign remove = slots.wr_en && (slots.wr_plate == '0);

	always_ff @(posedge clock) begin
		for (int f = 1; f <= num_floors; f++) begin
			for (int p = 0; p < 2; p++) begin
				if (store && slots.wr_floor == floor_t'(f) && slots.wr_place == place_t'(p)) begin
					counts[f][p] <= '0;
					rates[f][p] <= rate_of(slots.wr_plate);
				end else if (occupied[f][p]) begin
					counts[f][p] <= sat_add(counts[f][p], rates[f][p]);
				end
			end
		end
	end

	// Fee holds until the next removal
	always_ff @(posedge clock) begin
		if (reset) begin
			occupied <= '0;
			fee <= '0;
		end else begin
			if (store) begin
				occupied[slots.wr_floor][slots.wr_place] <= 1'b1;
			end
			if (remove) begin
				occupied[slots.wr_floor][slots.wr_place] <= 1'b0;
				fee <= counts[slots.wr_floor][slots.wr_place];
			end
		end
	end

endmodule

`default_nettype wire

/* logic/slot_allocator.sv */
// Free-place selection for the car class of the head order
`timescale 1ns/1ps
`default_nettype none

module slot_allocator
	import parking_pkg::*;
(
	input lot_map_t lot,
	order_if.monitor orders,
	output logic found,
	output floor_t floor,
	output place_t place
);

	logic disabled;
	logic suv;
	logic even_full;

	assign disabled = (orders.plate[15:12] == class_disabled);
	assign suv = orders.plate[0];

	// Sedans overflow to odd floors only once every even place is taken
	always_comb begin
		even_full = 1'b1;
		for (int f = 2; f <= num_floors; f += 2) begin
			if (lot[f][0] == '0 || lot[f][1] == '0) begin
				even_full = 1'b0;
			end
		end
	end

	// Scan top down so the lowest usable floor is kept, left over right
	always_comb begin
		found = 1'b0;
		floor = '0;
		place = 1'b0;
		for (int f = num_floors; f >= 1; f--) begin
			if ((f % 2 == 1) ? (suv || even_full) : !suv) begin
				if (lot[f][1] == '0) begin
					found = 1'b1;
					floor = floor_t'(f);
					place = 1'b1;
				end
				// Reserved left places
				if (lot[f][0] == '0 && (disabled || f > reserved_top_floor)) begin
					found = 1'b1;
					floor = floor_t'(f);
					place = 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* logic/slot_table.sv */
// Plate store of the fourteen places, plate lookup and free-place counts
`timescale 1ns/1ps
`default_nettype none

module slot_table
	import parking_pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	slot_if.storage slots,
	output lot_map_t lot,
	output logic [3:0] empty_sedan,
	output logic [3:0] empty_suv
);

	always_ff @(posedge clock) begin
		if (reset) begin
			lot <= '0;
		end else if (slots.wr_en) begin
			lot[slots.wr_floor][slots.wr_place] <= slots.wr_plate;
		end
	end

	// Lowest floor wins, right place before left
	always_comb begin
		slots.hit = 1'b0;
		slots.hit_floor = '0;
		slots.hit_place = 1'b0;
		for (int f = num_floors; f >= 1; f--) begin
			if (slots.lookup_plate != '0 && lot[f][0] == slots.lookup_plate) begin
				slots.hit = 1'b1;
				slots.hit_floor = floor_t'(f);
				slots.hit_place = 1'b0;
			end
			if (slots.lookup_plate != '0 && lot[f][1] == slots.lookup_plate) begin
				slots.hit = 1'b1;
				slots.hit_floor = floor_t'(f);
				slots.hit_place = 1'b1;
			end
		end
	end

	// Even floors hold sedans, odd floors SUVs
	always_comb begin
		empty_sedan = 4'd0;
		empty_suv = 4'd0;
		for (int f = 1; f <= num_floors; f++) begin
			for (int p = 0; p < 2; p++) begin
				if (lot[f][p] == '0) begin
					if (f % 2 == 0) begin
						empty_sedan = empty_sedan + 4'd1;
					end else begin
						empty_suv = empty_suv + 4'd1;
					end
				end
			end
		end
	end

	// The allocator and the lift must agree with the stored map
	a_store_into_empty: assert property (
		@(posedge clock) disable iff (reset)
		(slots.wr_en && slots.wr_plate != '0) |-> lot[slots.wr_floor][slots.wr_place] == '0
	) else $error("slot_table: store into an occupied place");

	a_remove_from_full: assert property (
		@(posedge clock) disable iff (reset)
		(slots.wr_en && slots.wr_plate == '0) |-> lot[slots.wr_floor][slots.wr_place] != '0
	) else $error("slot_table: removal from an empty place");

endmodule

`default_nettype wire

/* logic/order_queue.sv */
// Eight-entry FIFO of pending park and retrieve orders
`timescale 1ns/1ps
`default_nettype none

module order_queue
	import parking_pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire logic park_request,
	input wire logic retrieve_request,
	input plate_t plate,
	output logic queue_full,
	order_if.source orders
);

	plate_t plate_mem [queue_depth];
	logic exit_mem [queue_depth];
	queue_index_t head;
	queue_index_t tail;
	logic [3:0] count;
	logic push;

	assign queue_full = (count == 4'(queue_depth));
	assign push = (park_request || retrieve_request) && !queue_full;

	// Head entry straight from storage
	assign orders.valid = (count != 4'd0);
	assign orders.exit = exit_mem[head];
	assign orders.plate = plate_mem[head];

	always_ff @(posedge clock) begin
		if (push) begin
			plate_mem[tail] <= plate;
			exit_mem[tail] <= retrieve_request;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			// Pointers wrap naturally at eight entries
			if (push) begin
				tail <= tail + 3'd1;
			end
			if (orders.pop) begin
				head <= head + 3'd1;
			end
			case ({push, orders.pop})
				2'b10: count <= count + 4'd1;
				2'b01: count <= count - 4'd1;
				default: count <= count;
			endcase
		end
	end

	// Requests never arrive while full, and the lift only pops a valid head
	a_no_strobe_when_full: assert property (
		@(posedge clock) disable iff (reset)
		(park_request || retrieve_request) |-> !queue_full
	) else $error("order_queue: request while queue_full");

	a_pop_needs_valid: assert property (
		@(posedge clock) disable iff (reset)
		orders.pop |-> orders.valid
	) else $error("order_queue: pop with empty queue");

endmodule

`default_nettype wire

/* logic/lot_ifs.sv */
// order_if between the order queue and the lift
// slot_if between the lift, the slot table and the fee meter
`timescale 1ns/1ps
`default_nettype none

interface order_if
	import parking_pkg::*;
();
	logic valid;
	logic exit;
	plate_t plate;
	logic pop;

	// Head entry of the queue
	modport source (output valid, exit, plate, input pop);
	modport sink (input valid, exit, plate, output pop);
	modport monitor (input plate);
endinterface

interface slot_if
	import parking_pkg::*;
();
	logic wr_en;
	floor_t wr_floor;
	place_t wr_place;
	plate_t wr_plate;
	plate_t lookup_plate;
	logic hit;
	floor_t hit_floor;
	place_t hit_place;

	// Nonzero wr_plate stores a car, zero removes it
	modport lift (
		output wr_en, wr_floor, wr_place, wr_plate, lookup_plate,
		input hit, hit_floor, hit_place
	);
	modport storage (
		input wr_en, wr_floor, wr_place, wr_plate, lookup_plate,
		output hit, hit_floor, hit_place
	);
	modport monitor (input wr_en, wr_floor, wr_place, wr_plate);
endinterface

`default_nettype wire

/* logic/parking_pkg.sv */
// Lot geometry, plate classes, tariffs and queue sizing
// Shared types for the car park design
`default_nettype none

package parking_pkg;

	// Seven parking floors above the ground-floor entrance
	localparam int num_floors = 7;

	typedef logic [2:0] floor_t;
	typedef logic place_t;

	// Plate value 0 marks an empty place
	typedef logic [15:0] plate_t;

	// Indexed as lot[floor][place], floor 1..7, place 0 left and 1 right
	typedef plate_t [num_floors:1][1:0] lot_map_t;

	typedef logic [7:0] fee_t;

	// Top nibble of the plate
	localparam logic [3:0] class_disabled = 4'h9;
	localparam logic [3:0] class_hybrid = 4'h8;

	// Fee added per parked cycle
	localparam fee_t rate_disabled = 8'd0;
	localparam fee_t rate_hybrid = 8'd1;
	localparam fee_t rate_standard = 8'd2;
	localparam fee_t fee_max = 8'd255;

	// Left places up to this floor are for disabled cars only
	localparam floor_t reserved_top_floor = 3'd2;

	localparam int queue_depth = 8;
	typedef logic [2:0] queue_index_t;

endpackage

`default_nettype wire
